//--- verilog.f
src/buf_pkg.sv
src/cfg_bus_if.sv
src/layout_regs.sv
src/capture_seq.sv
src/sample_ram.sv
src/host_read_port.sv
src/data_buffer_top.sv
bench/data_buffer_properties.sv
bench/data_buffer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of the data buffer testbench
# the run counts as passed only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module data_buffer_tb \
    -f verilog.f -o data_buffer_sim \
    && ./obj_dir/data_buffer_sim | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- bench/data_buffer_tb.sv
/*
 * testbench of the sample-capture buffer
 *   clock, reset, timestamp counter and source mux model
 *   directed tests for capture, completion, read map, restart,
 *   layout lockout and the wide timestamp flag
 *   error counting and a cycle watchdog
 */

`timescale 1ns/100ps

module data_buffer_tb;

    localparam int ADDR_W = 10;
    // buffer block base and status word on the host bus
    localparam logic [15:0] mem_base  = 16'h7000;
    localparam logic [15:0] status_rd = 16'h7800;

    // rough step costs in clocks for the watchdog limit
    localparam int write_cost = 2;
    localparam int arm_cost   = 6;
    localparam int fire_cost  = 26;
    localparam int read_cost  = 4;
    localparam int timeout_cycles = 2 * (10 + 16 * write_cost + 3 * arm_cost
                                         + 4 * fire_cost + 26 * read_cost);

    logic        clkbuffer;
    logic        rst_n;
    logic [31:0] ts;
    logic        data_fb_wen;
    logic [31:0] input_data;
    logic [3:0]  data_type;
    logic [3:0]  data_channel;
    logic [3:0]  data_format;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic [15:0] reg_raddr;
    logic        prog_restart;
    logic [31:0] reg_rdata;
    logic [15:0] buf_status;

    // stamp is a base plus a free running tick that holds during a sample
    logic [31:0] ts_base;
    logic [31:0] tick;
    logic        ts_hold;

    // layout under test with one entry per signal
    logic [3:0]  lay_type [16];
    logic [3:0]  lay_chan [16];
    logic [3:0]  lay_fmt  [16];

    int          check_cnt;
    int          err_cnt;
    int          cycle_cnt;

    data_buffer_top #(.ADDR_W(ADDR_W)) data_buffer_top_inst (
        .clkbuffer    (clkbuffer),
        .rst_n        (rst_n),
        .ts           (ts),
        .data_fb_wen  (data_fb_wen),
        .input_data   (input_data),
        .data_type    (data_type),
        .data_channel (data_channel),
        .data_format  (data_format),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .reg_raddr    (reg_raddr),
        .prog_restart (prog_restart),
        .reg_rdata    (reg_rdata),
        .buf_status   (buf_status)
    );

    // ------------------------------
    // models and expected words
    // ------------------------------
    // source word is a marker byte over type, channel and format
    function automatic logic [31:0] source_word(input logic [3:0] t, input logic [3:0] c,
                                                input logic [3:0] f);
        return {8'hA5, 12'h000, t, c, f};
    endfunction

    // stamp word has marker bit 15, the wide flag in bit 14 and the low 14 stamp bits
    function automatic logic [31:0] stamp_word(input logic [31:0] t);
        logic wide;
        wide = t > 32'h0000_3FFF;
        return {16'h0000, 1'b1, wide, t[13:0]};
    endfunction

    // outside mux answers the select within the same cycle
    assign input_data = source_word(data_type, data_channel, data_format);
    assign ts         = ts_base + tick;

    initial begin
        clkbuffer = 1'b0;
        forever #2 clkbuffer = ~clkbuffer;
    end

    initial begin
        tick = '0;
        forever begin
            @(negedge clkbuffer);
            if (!ts_hold) begin
                tick = tick + 32'd1;
            end
        end
    end

    // watchdog ends a run that stops making progress
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clkbuffer);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("Test failed");
        $finish;
    end

    // ------------------------------
    // bus and strobe tasks
    // ------------------------------
    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] want);
        check_cnt++;
        assert (got === want) else begin
            err_cnt++;
            $display("ERR %0d ns: %s read 0x%08h, expected 0x%08h", $time, what, got, want);
        end
    endtask

    task automatic write_reg(input buf_pkg::reg_sel_e sel, input logic [31:0] data);
        @(negedge clkbuffer);
        reg_waddr = {buf_pkg::addr_data_buf, sel, 4'h0, buf_pkg::off_data_struct};
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(negedge clkbuffer);
        reg_wen   = 1'b0;
    endtask

    // count and samples go first and the last description arms
    task automatic write_layout(input int n_sig, input int n_smp);
        write_reg(buf_pkg::sel_sig_num, 32'(n_sig));
        write_reg(buf_pkg::sel_sample_num, 32'(n_smp));
        for (int k = 0; k < n_sig; k++) begin
            write_reg(buf_pkg::sel_sig_spec,
                      {16'h0000, lay_type[k], 4'h0, lay_chan[k], lay_fmt[k]});
        end
    endtask

    task automatic wait_busy(input logic level);
        while (buf_status[15] !== level) begin
            @(negedge clkbuffer);
        end
    endtask

    // one sample freezes the stamp, raises the strobe and waits for the pointer
    task automatic fire_trigger(input int first_addr, input int n_sig,
                                output logic [31:0] held_ts);
        @(negedge clkbuffer);
        ts_hold = 1'b1;
        @(posedge clkbuffer);
        held_ts = ts;
        @(negedge clkbuffer);
        data_fb_wen = 1'b1;
        while (buf_status[ADDR_W-1:0] != ADDR_W'(first_addr + 1 + n_sig)) begin
            @(negedge clkbuffer);
        end
        // last word lands one clock after the pointer reaches it
        @(negedge clkbuffer);
        data_fb_wen = 1'b0;
        ts_hold     = 1'b0;
        // let the low level through the synchronizer
        repeat (4) @(negedge clkbuffer);
    endtask

    task automatic read_word(input logic [15:0] addr, input logic [31:0] want,
                             input string what);
        @(negedge clkbuffer);
        reg_raddr = addr;
        // address register and then the RAM output register
        repeat (2) @(posedge clkbuffer);
        @(negedge clkbuffer);
        check_word(what, reg_rdata, want);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic capture_layout();
        logic [31:0] held0;
        logic [31:0] held1;
        lay_type[0] = buf_pkg::typ_pot;
        lay_chan[0] = 4'd2;
        lay_fmt[0]  = 4'd1;
        lay_type[1] = buf_pkg::typ_cur;
        lay_chan[1] = 4'd5;
        lay_fmt[1]  = 4'd0;
        lay_type[2] = buf_pkg::typ_enc_vel;
        lay_chan[2] = 4'd1;
        lay_fmt[2]  = 4'd3;
        write_layout(3, 2);
        wait_busy(1'b1);
        read_word(status_rd, 32'h0000_8000, "status after arming");
        fire_trigger(0, 3, held0);
        // still busy between the two samples
        read_word(status_rd, 32'h0000_8004, "status after sample 1");
        fire_trigger(4, 3, held1);
        read_word(status_rd, 32'h0000_0008, "status after sample 2");
        read_word(mem_base | 16'd1, stamp_word(held0), "stamp of sample 1");
        read_word(mem_base | 16'd5, stamp_word(held1), "stamp of sample 2");
        for (int k = 0; k < 3; k++) begin
            read_word(mem_base + 16'(2 + k), source_word(lay_type[k], lay_chan[k], lay_fmt[k]),
                      "signal word of sample 1");
            read_word(mem_base + 16'(6 + k), source_word(lay_type[k], lay_chan[k], lay_fmt[k]),
                      "signal word of sample 2");
        end
    endtask

    task automatic read_map();
        read_word(status_rd, 32'h0000_0008, "status word");
        read_word(16'h7801, 32'h0000_0000, "unmapped 0x801");
        read_word(16'h7C00, 32'h0000_0000, "unmapped 0xC00");
        read_word(16'h7FFF, 32'h0000_0000, "unmapped 0xFFF");
    endtask

    task automatic restart_hold();
        logic [31:0] word6;
        word6 = source_word(lay_type[0], lay_chan[0], lay_fmt[0]);
        read_word(mem_base | 16'd6, word6, "memory before restart");
        reg_raddr    = status_rd;
        prog_restart = 1'b1;
        repeat (2) @(posedge clkbuffer);
        @(negedge clkbuffer);
        check_word("status during restart", reg_rdata, 32'h0000_0008);
        // RAM should still point at address 6
        reg_raddr    = mem_base | 16'd6;
        prog_restart = 1'b0;
        #1;
        check_word("memory right after restart", reg_rdata, word6);
    endtask

    task automatic write_lockout();
        logic [31:0] held;
        lay_type[0] = buf_pkg::typ_enc_pos;
        lay_chan[0] = 4'd7;
        lay_fmt[0]  = 4'd2;
        lay_type[1] = buf_pkg::typ_cur;
        lay_chan[1] = 4'd3;
        lay_fmt[1]  = 4'd4;
        write_layout(2, 1);
        wait_busy(1'b1);
        // a competing layout while the capture runs must be dropped
        write_reg(buf_pkg::sel_sig_num, 32'd4);
        write_reg(buf_pkg::sel_sample_num, 32'd3);
        write_reg(buf_pkg::sel_sig_spec, 32'h0000_4F0F);
        fire_trigger(0, 2, held);
        read_word(status_rd, 32'h0000_0003, "status after locked capture");
        read_word(mem_base | 16'd1, stamp_word(held), "stamp of locked capture");
        for (int k = 0; k < 2; k++) begin
            read_word(mem_base + 16'(2 + k), source_word(lay_type[k], lay_chan[k], lay_fmt[k]),
                      "signal word of locked capture");
        end
    endtask

    task automatic wide_stamp();
        logic [31:0] held;
        lay_type[0] = buf_pkg::typ_enc_vel;
        lay_chan[0] = 4'd9;
        lay_fmt[0]  = 4'd6;
        write_layout(1, 1);
        wait_busy(1'b1);
        // stamp well past 14 bits
        @(negedge clkbuffer);
        ts_base = 32'h0001_2340;
        fire_trigger(0, 1, held);
        read_word(status_rd, 32'h0000_0002, "status after wide stamp");
        read_word(mem_base | 16'd1, stamp_word(held), "wide stamp word");
        read_word(mem_base | 16'd2, source_word(lay_type[0], lay_chan[0], lay_fmt[0]),
                  "signal word of new layout");
    endtask

    initial begin
        rst_n        = 1'b0;
        data_fb_wen  = 1'b0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        reg_raddr    = '0;
        prog_restart = 1'b0;
        ts_base      = '0;
        ts_hold      = 1'b0;
        check_cnt    = 0;
        err_cnt      = 0;
        repeat (10) @(posedge clkbuffer);
        @(negedge clkbuffer);
        rst_n = 1'b1;
        capture_layout();
        read_map();
        restart_hold();
        write_lockout();
        wide_stamp();
        $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/data_buffer_properties.sv
/*
 * concurrent checks on the capture sequencer
 *   no RAM write in the idle or waiting states
 *   write address steps by one per word
 *   busy held through the signal words
 */

`timescale 1ns/100ps

module data_buffer_properties #(
    parameter int ADDR_W = 10
) (
    input logic                clkbuffer,
    input logic                rst_n,
    input buf_pkg::cap_state_e state,
    input logic                ram_wen,
    input logic [ADDR_W-1:0]   ram_waddr,
    input logic                busy
);

    // writes belong to a sample only
    wen_in_sample: assert property (
        @(posedge clkbuffer) disable iff (!rst_n)
        ram_wen |-> !(state == buf_pkg::st_idle || state == buf_pkg::st_ready)
    ) else $error("RAM write enable high outside a sample");

    // each stored word sits right after the previous one
    addr_step: assert property (
        @(posedge clkbuffer) disable iff (!rst_n)
        ram_wen |-> ram_waddr == $past(ram_waddr) + ADDR_W'(1)
    ) else $error("write address did not step by one");

    // layout stays locked until the sample is complete
    busy_in_loop: assert property (
        @(posedge clkbuffer) disable iff (!rst_n)
        state == buf_pkg::st_loop_main |=> busy
    ) else $error("busy dropped during the signal words");

endmodule

// attached to every capture sequencer
bind capture_seq data_buffer_properties #(.ADDR_W(ADDR_W)) seq_props (
    .clkbuffer (clkbuffer),
    .rst_n     (rst_n),
    .state     (state),
    .ram_wen   (ram_wen),
    .ram_waddr (ram_waddr),
    .busy      (busy_q)
);

//--- src/data_buffer_top.sv
/*
 * sample-capture buffer top level
 *   layout registers, capture sequencer, sample RAM, host read port
 *   source select exported to the outside mux
 */

`timescale 1ns/100ps

module data_buffer_top #(
    parameter int ADDR_W = 10
) (
    input  logic        clkbuffer,
    input  logic        rst_n,
    input  logic [31:0] ts,
    input  logic        data_fb_wen,
    input  logic [31:0] input_data,
    output logic [3:0]  data_type,
    output logic [3:0]  data_channel,
    output logic [3:0]  data_format,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    input  logic [15:0] reg_raddr,
    input  logic        prog_restart,
    output logic [31:0] reg_rdata,
    output logic [15:0] buf_status
);

    // ------------------------------
    // internal wiring
    // ------------------------------
    cfg_bus_if cfg ();

    logic              ram_wen;
    logic [ADDR_W-1:0] ram_waddr;
    logic [31:0]       ram_wdata;
    logic [ADDR_W-1:0] ram_raddr;
    logic [31:0]       ram_rdata;

    // current table entry drives the source mux
    assign data_type    = cfg.spec_type;
    assign data_channel = cfg.spec_channel;
    assign data_format  = cfg.spec_format;

    // ------------------------------
    // blocks
    // ------------------------------
    layout_regs u_layout_regs (
        .clkbuffer (clkbuffer),
        .rst_n     (rst_n),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .cfg       (cfg.layout)
    );

    capture_seq #(.ADDR_W(ADDR_W)) u_capture_seq (
        .clkbuffer   (clkbuffer),
        .rst_n       (rst_n),
        .data_fb_wen (data_fb_wen),
        .ts          (ts),
        .input_data  (input_data),
        .cfg         (cfg.seq),
        .ram_wen     (ram_wen),
        .ram_waddr   (ram_waddr),
        .ram_wdata   (ram_wdata)
    );

    sample_ram #(.ADDR_W(ADDR_W)) u_sample_ram (
        .clkbuffer (clkbuffer),
        .wen       (ram_wen),
        .waddr     (ram_waddr),
        .wdata     (ram_wdata),
        .raddr     (ram_raddr),
        .rdata     (ram_rdata)
    );

    // status reports the write pointer of the sequencer
    host_read_port #(.ADDR_W(ADDR_W)) u_host_read_port (
        .clkbuffer    (clkbuffer),
        .rst_n        (rst_n),
        .reg_raddr    (reg_raddr),
        .prog_restart (prog_restart),
        .busy         (cfg.busy),
        .waddr        (ram_waddr),
        .ram_rdata    (ram_rdata),
        .ram_raddr    (ram_raddr),
        .reg_rdata    (reg_rdata),
        .buf_status   (buf_status)
    );

endmodule

//--- src/host_read_port.sv
/*
 * host read side of the buffer
 *   RAM read address register with last-address hold on restart
 *   status word and read data select
 */

`timescale 1ns/100ps

module host_read_port #(
    parameter int ADDR_W = 10
) (
    input  logic              clkbuffer,
    input  logic              rst_n,
    input  logic [15:0]       reg_raddr,
    input  logic              prog_restart,
    input  logic              busy,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [31:0]       ram_rdata,
    output logic [ADDR_W-1:0] ram_raddr,
    output logic [31:0]       reg_rdata,
    output logic [15:0]       buf_status
);

    // ------------------------------
    // read address
    // ------------------------------
    logic [ADDR_W-1:0] last_raddr;

    always_ff @(posedge clkbuffer or negedge rst_n) begin
        if (!rst_n) begin
            last_raddr <= '0;
            ram_raddr  <= '0;
        end else begin
            // remember the last address that hit memory
            if (!reg_raddr[11]) begin
                last_raddr <= reg_raddr[ADDR_W-1:0];
            end
            // on restart keep the RAM pointed at the last memory read
            if (prog_restart) begin
                ram_raddr <= last_raddr;
            end else begin
                ram_raddr <= reg_raddr[ADDR_W-1:0];
            end
        end
    end

    // ------------------------------
    // status and read select
    // ------------------------------
    // busy on top, write pointer at the bottom
    assign buf_status = {busy, {(15 - ADDR_W){1'b0}}, waddr};

    // bit 11 low is memory, one status word, the rest reads zero
    assign reg_rdata = !reg_raddr[11] ? ram_rdata
                     : (reg_raddr[11:0] == buf_pkg::status_addr) ? {16'd0, buf_status}
                     : 32'd0;

endmodule

//--- src/sample_ram.sv
/*
 * sample storage
 *   simple dual-port RAM, synchronous write, registered read
 */

`timescale 1ns/100ps

module sample_ram #(
    parameter int ADDR_W = 10
) (
    input  logic              clkbuffer,
    input  logic              wen,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [31:0]       wdata,
    input  logic [ADDR_W-1:0] raddr,
    output logic [31:0]       rdata
);

    // one word per address, depth set by ADDR_W
    logic [31:0] mem [2**ADDR_W];

    // write port
    always_ff @(posedge clkbuffer) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, data one clock after the address
    always_ff @(posedge clkbuffer) begin
        rdata <= mem[raddr];
    end

endmodule

//--- src/capture_seq.sv
/*
 * capture sequencer
 *   two-flop synchronizer and rising edge detect on the data-valid strobe
 *   capture FSM writing one timestamp word and one word per signal
 *   sample and signal counters, table index for the source mux
 */

`timescale 1ns/100ps

module capture_seq #(
    parameter int ADDR_W = 10
) (
    input  logic              clkbuffer,
    input  logic              rst_n,
    input  logic              data_fb_wen,
    input  logic [31:0]       ts,
    input  logic [31:0]       input_data,
    cfg_bus_if.seq            cfg,
    output logic              ram_wen,
    output logic [ADDR_W-1:0] ram_waddr,
    output logic [31:0]       ram_wdata
);

    // ------------------------------
    // strobe synchronizer
    // ------------------------------
    logic fb_s1;
    logic fb_s2;
    logic fb_prev;
    logic trigger;

    always_ff @(posedge clkbuffer or negedge rst_n) begin
        if (!rst_n) begin
            fb_s1   <= 1'b0;
            fb_s2   <= 1'b0;
            fb_prev <= 1'b0;
        end else begin
            fb_s1   <= data_fb_wen;
            fb_s2   <= fb_s1;
            fb_prev <= fb_s2;
        end
    end

    // one cycle pulse on the synchronized rising edge
    assign trigger = fb_s2 && !fb_prev;

    // ------------------------------
    // timestamp word
    // ------------------------------
    logic        ts_over14;
    logic [31:0] ts_word;

    // flag when the stamp does not fit in 14 bits
    assign ts_over14 = |ts[31:14];
    assign ts_word   = {16'd0, 1'b1, ts_over14, ts[13:0]};

    // ------------------------------
    // capture FSM
    // ------------------------------
    buf_pkg::cap_state_e          state;
    logic                         busy_q;
    logic [buf_pkg::sample_w-1:0] smp_cnt;
    // index of the signal being captured, also the table index
    logic [3:0]                   word_cnt;

    always_ff @(posedge clkbuffer or negedge rst_n) begin
        if (!rst_n) begin
            state     <= buf_pkg::st_idle;
            busy_q    <= 1'b0;
            ram_wen   <= 1'b0;
            ram_waddr <= '0;
            smp_cnt   <= '0;
            word_cnt  <= '0;
        end else begin
            case (state)
                buf_pkg::st_idle: begin
                    // fresh layout, start a capture at address 0
                    if (cfg.armed) begin
                        busy_q    <= 1'b1;
                        ram_wen   <= 1'b0;
                        ram_waddr <= '0;
                        smp_cnt   <= '0;
                        state     <= buf_pkg::st_ready;
                    end
                end
                buf_pkg::st_ready: begin
                    if (trigger && smp_cnt < cfg.sample_num) begin
                        word_cnt <= '0;
                        smp_cnt  <= smp_cnt + buf_pkg::sample_w'(1);
                        state    <= buf_pkg::st_time_stamp;
                    end else if (smp_cnt == cfg.sample_num) begin
                        // all samples stored, release the layout
                        busy_q <= 1'b0;
                        state  <= buf_pkg::st_idle;
                    end
                end
                buf_pkg::st_time_stamp: begin
                    ram_wen   <= 1'b1;
                    ram_waddr <= ram_waddr + ADDR_W'(1);
                    state     <= buf_pkg::st_loop_main;
                end
                buf_pkg::st_loop_main: begin
                    if (word_cnt < cfg.sig_num) begin
                        ram_wen   <= 1'b1;
                        ram_waddr <= ram_waddr + ADDR_W'(1);
                        word_cnt  <= word_cnt + 4'd1;
                    end else begin
                        // sample done, wait for the next strobe
                        ram_wen <= 1'b0;
                        state   <= buf_pkg::st_ready;
                    end
                end
                default: begin
                    state <= buf_pkg::st_idle;
                end
            endcase
        end
    end

    // ------------------------------
    // write data
    // ------------------------------
    // the source mux answers within the cycle word_cnt points at it
    always_ff @(posedge clkbuffer) begin
        if (state == buf_pkg::st_time_stamp) begin
            ram_wdata <= ts_word;
        end else if (state == buf_pkg::st_loop_main && word_cnt < cfg.sig_num) begin
            ram_wdata <= input_data;
        end
    end

    assign cfg.busy       = busy_q;
    assign cfg.spec_index = word_cnt;

endmodule

//--- src/layout_regs.sv
/*
 * capture layout registers
 *   host write decode for the buffer block
 *   signal count, 16-entry description table, sample count
 *   armed flag raised once the last description is in
 */

`timescale 1ns/100ps

module layout_regs (
    input  logic          clkbuffer,
    input  logic          rst_n,
    input  logic [15:0]   reg_waddr,
    input  logic [31:0]   reg_wdata,
    input  logic          reg_wen,
    cfg_bus_if.layout     cfg
);

    // ------------------------------
    // write decode
    // ------------------------------
    logic                 struct_wen;
    buf_pkg::reg_sel_e    sel;
    logic                 num_wr;
    logic                 spec_wr;
    logic                 smp_wr;

    // layout is frozen while a capture runs
    assign struct_wen = reg_wen
                     && reg_waddr[15:12] == buf_pkg::addr_data_buf
                     && reg_waddr[3:0] == buf_pkg::off_data_struct
                     && !cfg.busy;

    assign sel     = buf_pkg::reg_sel_e'(reg_waddr[11:8]);
    assign num_wr  = struct_wen && sel == buf_pkg::sel_sig_num;
    assign spec_wr = struct_wen && sel == buf_pkg::sel_sig_spec;
    assign smp_wr  = struct_wen && sel == buf_pkg::sel_sample_num;

    // ------------------------------
    // counts and armed flag
    // ------------------------------
    logic [3:0]                   sig_num_q;
    logic [3:0]                   spec_cnt;
    logic [buf_pkg::sample_w-1:0] sample_num_q;
    logic                         armed_q;

    always_ff @(posedge clkbuffer or negedge rst_n) begin
        if (!rst_n) begin
            sig_num_q    <= '0;
            spec_cnt     <= '0;
            sample_num_q <= '0;
            armed_q      <= 1'b0;
        end else begin
            // new count restarts the description list
            if (num_wr) begin
                sig_num_q <= reg_wdata[3:0];
                spec_cnt  <= '0;
            end
            // each description goes to the next slot
            if (spec_wr) begin
                spec_cnt <= spec_cnt + 4'd1;
            end
            if (smp_wr) begin
                sample_num_q <= reg_wdata[buf_pkg::sample_w-1:0];
            end
            // all descriptions in, arm and rewind the slot counter
            if (spec_cnt != 4'd0 && spec_cnt == sig_num_q) begin
                armed_q  <= 1'b1;
                spec_cnt <= '0;
            end
            // sequencer took the layout
            if (cfg.busy) begin
                armed_q <= 1'b0;
            end
        end
    end

    // ------------------------------
    // description table
    // ------------------------------
    buf_pkg::sig_type_e   type_tab    [16];
    logic [3:0]           channel_tab [16];
    logic [3:0]           format_tab  [16];

    always_ff @(posedge clkbuffer) begin
        if (spec_wr) begin
            // type 15:12, channel 7:4, format 3:0
            type_tab[spec_cnt]    <= buf_pkg::sig_type_e'(reg_wdata[15:12]);
            channel_tab[spec_cnt] <= reg_wdata[7:4];
            format_tab[spec_cnt]  <= reg_wdata[3:0];
        end
    end

    // entry lookup for the sequencer, no register in the path
    assign cfg.spec_type    = type_tab[cfg.spec_index];
    assign cfg.spec_channel = channel_tab[cfg.spec_index];
    assign cfg.spec_format  = format_tab[cfg.spec_index];

    assign cfg.sig_num    = sig_num_q;
    assign cfg.sample_num = sample_num_q;
    assign cfg.armed      = armed_q;

endmodule

//--- src/cfg_bus_if.sv
/*
 * capture layout bus between the layout registers and the sequencer
 *   layout side drives counts, armed flag and the addressed table entry
 *   sequencer side drives busy and the table index it wants
 */

`timescale 1ns/100ps

interface cfg_bus_if;

    // number of signals per sample, 1 to 15
    logic [3:0]                   sig_num;
    // number of samples to take
    logic [buf_pkg::sample_w-1:0] sample_num;
    // layout complete, capture may start
    logic                         armed;
    // capture in progress, layout locked
    logic                         busy;
    // table entry requested by the sequencer
    logic [3:0]                   spec_index;
    // fields of the requested entry, returned combinationally
    buf_pkg::sig_type_e           spec_type;
    logic [3:0]                   spec_channel;
    logic [3:0]                   spec_format;

    modport layout (
        output sig_num, sample_num, armed,
        output spec_type, spec_channel, spec_format,
        input  busy, spec_index
    );

    modport seq (
        output busy, spec_index,
        input  sig_num, sample_num, armed
    );

endinterface

//--- src/buf_pkg.sv
/*
 * shared definitions of the sample-capture buffer
 *   host address map codes and offsets
 *   field widths
 *   enums for layout register selects, signal sources and capture states
 */

package buf_pkg;

    // ------------------------------
    // host address map
    // ------------------------------
    // block code of the buffer, bits 15:12 of host addresses
    localparam logic [3:0] addr_data_buf = 4'd7;
    // layout write offset, bits 3:0 of the write address
    localparam logic [3:0] off_data_struct = 4'hB;
    // status word location within the block
    localparam logic [11:0] status_addr = 12'h800;

    // width of the sample count field
    localparam int sample_w = 11;

    // ------------------------------
    // enums
    // ------------------------------
    // layout register select, bits 11:8 of a layout write
    typedef enum logic [3:0] {
        sel_sig_num    = 4'd0,
        sel_sig_spec   = 4'd1,
        sel_sample_num = 4'd2
    } reg_sel_e;

    // source kinds the outside mux can present
    typedef enum logic [3:0] {
        typ_none    = 4'd0,
        typ_pot     = 4'd1,
        typ_cur     = 4'd2,
        typ_enc_pos = 4'd3,
        typ_enc_vel = 4'd4
    } sig_type_e;

    // capture sequencer states
    typedef enum logic [1:0] {
        st_idle       = 2'd0,
        st_ready      = 2'd1,
        st_time_stamp = 2'd2,
        st_loop_main  = 2'd3
    } cap_state_e;

endpackage
